//--- shfifo_pkg.sv
package shfifo_pkg;

  // ----------------------------------------------------------------------
  // Fixed sizes shared by every block
  // ----------------------------------------------------------------------

  // Width of one data word
  localparam int DATA_W = 16;
  // Address width of the shared RAM
  localparam int ADDR_W = 5;
  // Number of RAM entries, split between the two channels
  localparam int RAM_DEPTH = 32;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // Address window of one channel
  // Both ends are inclusive, base <= bound
  typedef struct packed {
    addr_t base;
    addr_t bound;
  } win_t;

  // One write into the shared RAM
  typedef struct packed {
    logic  valid;
    addr_t addr;
    data_t data;
  } wr_req_t;

  // ----------------------------------------------------------------------
  // Write arbiter state
  // ----------------------------------------------------------------------

  // Names the channel that wins the next conflict
  typedef enum logic {
    PRIO_CH0 = 1'b0,
    PRIO_CH1 = 1'b1
  } prio_e;

endpackage

//--- shfifo_push_ctrl.sv
module shfifo_push_ctrl #(
  parameter bit EnableBypass = 1
) (
  input  logic                clk,
  input  logic                reset,
  // Producer side
  input  logic                push_valid,
  input  shfifo_pkg::data_t   push_data,
  output logic                push_ready,
  // Channel window and status
  input  shfifo_pkg::win_t    win,
  input  logic                full,
  // From the pop control, the consumer can take the word directly
  input  logic                bypass_ready,
  // Shared RAM write port
  input  logic                wr_grant,
  output shfifo_pkg::wr_req_t wr_req,
  // Accepted push, for bookkeeping in the channel
  output logic                push_beat
);

  import shfifo_pkg::*;

  // Current write pointer inside the window
  addr_t wr_addr;
  // Word goes straight to the pop side this cycle
  logic  use_bypass;
  // Write actually lands in the RAM this cycle
  logic  wr_taken;

  // ----------------------------------------------------------------------
  // Steering
  // ----------------------------------------------------------------------

  // Bypass only exists when enabled
  assign use_bypass = EnableBypass && bypass_ready;

  // Ask for the RAM port only when the word cannot go around it
  assign wr_req.valid = push_valid && !full && !use_bypass;
  assign wr_req.addr  = wr_addr;
  assign wr_req.data  = push_data;

  assign wr_taken = wr_req.valid && wr_grant;

  // Ready needs room plus a path, bypass or a granted write
  assign push_ready = !full && (use_bypass || wr_grant);
  assign push_beat  = push_valid && push_ready;

  // ----------------------------------------------------------------------
  // Write-address counter
  // ----------------------------------------------------------------------

  // Starts at base, steps on each granted write
  // Wraps from bound back to base
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_addr <= win.base;
    end else if (wr_taken) begin
      if (wr_addr == win.bound) begin
        wr_addr <= win.base;
      end else begin
        wr_addr <= wr_addr + addr_t'(1);
      end
    end
  end

endmodule

//--- shfifo_pop_ctrl.sv
module shfifo_pop_ctrl #(
  parameter bit EnableBypass = 1
) (
  input  logic              clk,
  input  logic              reset,
  // Consumer side
  output logic              pop_valid,
  output shfifo_pkg::data_t pop_data,
  input  logic              pop_ready,
  // Channel window and status
  input  shfifo_pkg::win_t  win,
  input  logic              empty,
  // Producer side, seen for the bypass path
  input  logic              push_valid,
  input  shfifo_pkg::data_t push_data,
  // Shared RAM read port of this channel
  input  shfifo_pkg::data_t rd_data,
  output shfifo_pkg::addr_t rd_addr,
  // To the push control
  output logic              bypass_ready,
  // Pop served from the RAM head
  output logic              ram_pop
);

  import shfifo_pkg::*;

  // Head pointer inside the window
  addr_t rd_ptr;
  // Pop side shows the producer's word this cycle
  logic  show_bypass;

  // ----------------------------------------------------------------------
  // Output selection
  // ----------------------------------------------------------------------

  // Nothing stored, so the push word is the head
  assign show_bypass = EnableBypass && empty;

  assign pop_valid = show_bypass ? push_valid : !empty;
  assign pop_data  = show_bypass ? push_data : rd_data;

  // Consumer can absorb a pushed word in the same cycle
  assign bypass_ready = show_bypass && pop_ready;

  // Only stored words move the read pointer
  assign ram_pop = pop_valid && pop_ready && !empty;

  assign rd_addr = rd_ptr;

  // ----------------------------------------------------------------------
  // Read-address counter
  // ----------------------------------------------------------------------

  // Same wrap rule as the write side
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= win.base;
    end else if (ram_pop) begin
      if (rd_ptr == win.bound) begin
        rd_ptr <= win.base;
      end else begin
        rd_ptr <= rd_ptr + addr_t'(1);
      end
    end
  end

endmodule

//--- shfifo_channel.sv
module shfifo_channel #(
  parameter bit EnableBypass = 1
) (
  input  logic                clk,
  input  logic                reset,
  // Push side
  input  logic                push_valid,
  input  shfifo_pkg::data_t   push_data,
  output logic                push_ready,
  // Pop side
  output logic                pop_valid,
  output shfifo_pkg::data_t   pop_data,
  input  logic                pop_ready,
  // Fixed window in the shared RAM
  input  shfifo_pkg::win_t    win,
  // Shared write port through the arbiter
  input  logic                wr_grant,
  output shfifo_pkg::wr_req_t wr_req,
  // Own read port
  output shfifo_pkg::addr_t   rd_addr,
  input  shfifo_pkg::data_t   rd_data
);

  import shfifo_pkg::*;

  // One extra bit so a full window never aliases to zero
  typedef logic [ADDR_W:0] count_t;

  count_t occupancy;
  count_t capacity;
  logic   full;
  logic   empty;
  logic   bypass_ready;
  logic   push_beat;
  logic   ram_pop;
  logic   ram_push;

  // ----------------------------------------------------------------------
  // Occupancy
  // ----------------------------------------------------------------------

  // Window size, bound is inclusive
  assign capacity = count_t'(win.bound) - count_t'(win.base) + count_t'(1);

  // A push that did not bypass went into the RAM
  assign ram_push = push_beat && !bypass_ready;

  // Write and pop in one cycle cancel out
  always_ff @(posedge clk) begin
    if (reset) begin
      occupancy <= '0;
    end else if (ram_push && !ram_pop) begin
      occupancy <= occupancy + count_t'(1);
    end else if (ram_pop && !ram_push) begin
      occupancy <= occupancy - count_t'(1);
    end
  end

  assign full  = (occupancy == capacity);
  assign empty = (occupancy == '0);

  // ----------------------------------------------------------------------
  // Push and pop controls
  // ----------------------------------------------------------------------

  shfifo_push_ctrl #(
    .EnableBypass(EnableBypass)
  ) u_push_ctrl (
    .clk         (clk),
    .reset       (reset),
    .push_valid  (push_valid),
    .push_data   (push_data),
    .push_ready  (push_ready),
    .win         (win),
    .full        (full),
    .bypass_ready(bypass_ready),
    .wr_grant    (wr_grant),
    .wr_req      (wr_req),
    .push_beat   (push_beat)
  );

  shfifo_pop_ctrl #(
    .EnableBypass(EnableBypass)
  ) u_pop_ctrl (
    .clk         (clk),
    .reset       (reset),
    .pop_valid   (pop_valid),
    .pop_data    (pop_data),
    .pop_ready   (pop_ready),
    .win         (win),
    .empty       (empty),
    .push_valid  (push_valid),
    .push_data   (push_data),
    .rd_data     (rd_data),
    .rd_addr     (rd_addr),
    .bypass_ready(bypass_ready),
    .ram_pop     (ram_pop)
  );

endmodule

//--- shfifo_wr_arbiter.sv
module shfifo_wr_arbiter (
  input  logic                clk,
  input  logic                reset,
  // Requests from the two channels
  input  shfifo_pkg::wr_req_t req0,
  input  shfifo_pkg::wr_req_t req1,
  // One grant per channel, never both
  output logic                grant0,
  output logic                grant1,
  // Winning request, to the RAM write port
  output shfifo_pkg::wr_req_t ram_wr
);

  import shfifo_pkg::*;

  prio_e prio;

  // ----------------------------------------------------------------------
  // Grant
  // ----------------------------------------------------------------------

  // Lone requester always wins
  // On a conflict the priority state decides
  assign grant0 = req0.valid && (!req1.valid || prio == PRIO_CH0);
  assign grant1 = req1.valid && (!req0.valid || prio == PRIO_CH1);

  // Idle port carries no write
  always_comb begin
    ram_wr = '0;
    if (grant0) begin
      ram_wr = req0;
    end else if (grant1) begin
      ram_wr = req1;
    end
  end

  // ----------------------------------------------------------------------
  // Round-robin state
  // ----------------------------------------------------------------------

  // Priority passes to the other channel after any grant
  always_ff @(posedge clk) begin
    if (reset) begin
      prio <= PRIO_CH0;
    end else if (grant0) begin
      prio <= PRIO_CH1;
    end else if (grant1) begin
      prio <= PRIO_CH0;
    end
  end

endmodule

//--- shfifo_ram.sv
module shfifo_ram (
  input  logic                clk,
  // Single write port, shared through the arbiter
  input  shfifo_pkg::wr_req_t wr,
  // Read port of channel 0
  input  shfifo_pkg::addr_t   rd_addr0,
  output shfifo_pkg::data_t   rd_data0,
  // Read port of channel 1
  input  shfifo_pkg::addr_t   rd_addr1,
  output shfifo_pkg::data_t   rd_data1
);

  import shfifo_pkg::*;

  // Storage array
  data_t mem [RAM_DEPTH];

  // Write lands at the rising edge
  always_ff @(posedge clk) begin
    if (wr.valid) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // Combinational reads
  // A word written at edge k is visible right after that edge
  assign rd_data0 = mem[rd_addr0];
  assign rd_data1 = mem[rd_addr1];

endmodule

//--- shfifo_top.sv
module shfifo_top #(
  // Entries of channel 0, 1 to 31, channel 1 takes the rest
  parameter int Ch0Entries   = 4,
  parameter bit EnableBypass = 1
) (
  input  logic              clk,
  input  logic              reset,
  // Channel 0
  input  logic              push_valid0,
  input  shfifo_pkg::data_t push_data0,
  output logic              push_ready0,
  output logic              pop_valid0,
  output shfifo_pkg::data_t pop_data0,
  input  logic              pop_ready0,
  // Channel 1
  input  logic              push_valid1,
  input  shfifo_pkg::data_t push_data1,
  output logic              push_ready1,
  output logic              pop_valid1,
  output shfifo_pkg::data_t pop_data1,
  input  logic              pop_ready1
);

  import shfifo_pkg::*;

  // ----------------------------------------------------------------------
  // Address windows
  // ----------------------------------------------------------------------

  // Channel 0 sits at the bottom of the RAM
  localparam win_t Win0 = '{
    base:  addr_t'(0),
    bound: addr_t'(Ch0Entries - 1)
  };

  // Channel 1 runs up to the last entry
  localparam win_t Win1 = '{
    base:  addr_t'(Ch0Entries),
    bound: addr_t'(RAM_DEPTH - 1)
  };

  wr_req_t req0;
  wr_req_t req1;
  wr_req_t ram_wr;
  logic    grant0;
  logic    grant1;
  addr_t   rd_addr0;
  addr_t   rd_addr1;
  data_t   rd_data0;
  data_t   rd_data1;

  // ----------------------------------------------------------------------
  // Channels
  // ----------------------------------------------------------------------

  shfifo_channel #(
    .EnableBypass(EnableBypass)
  ) u_ch0 (
    .clk       (clk),
    .reset     (reset),
    .push_valid(push_valid0),
    .push_data (push_data0),
    .push_ready(push_ready0),
    .pop_valid (pop_valid0),
    .pop_data  (pop_data0),
    .pop_ready (pop_ready0),
    .win       (Win0),
    .wr_grant  (grant0),
    .wr_req    (req0),
    .rd_addr   (rd_addr0),
    .rd_data   (rd_data0)
  );

  shfifo_channel #(
    .EnableBypass(EnableBypass)
  ) u_ch1 (
    .clk       (clk),
    .reset     (reset),
    .push_valid(push_valid1),
    .push_data (push_data1),
    .push_ready(push_ready1),
    .pop_valid (pop_valid1),
    .pop_data  (pop_data1),
    .pop_ready (pop_ready1),
    .win       (Win1),
    .wr_grant  (grant1),
    .wr_req    (req1),
    .rd_addr   (rd_addr1),
    .rd_data   (rd_data1)
  );

  // ----------------------------------------------------------------------
  // Shared write port and storage
  // ----------------------------------------------------------------------

  shfifo_wr_arbiter u_wr_arbiter (
    .clk   (clk),
    .reset (reset),
    .req0  (req0),
    .req1  (req1),
    .grant0(grant0),
    .grant1(grant1),
    .ram_wr(ram_wr)
  );

  shfifo_ram u_ram (
    .clk     (clk),
    .wr      (ram_wr),
    .rd_addr0(rd_addr0),
    .rd_data0(rd_data0),
    .rd_addr1(rd_addr1),
    .rd_data1(rd_data1)
  );

endmodule

//--- shfifo_properties.sv
module shfifo_properties #(
  // Which group of checks this instance runs
  parameter bit CheckGrants = 1'b1,
  parameter bit CheckPush   = 1'b1
) (
  input logic              clk,
  input logic              reset,
  // Arbiter grants
  input logic              grant0,
  input logic              grant1,
  // Push handshake of one channel
  input logic              push_valid,
  input logic              push_ready,
  input shfifo_pkg::data_t push_data
);

  // Number of failed checks in this instance
  int fail_count;

  initial fail_count = 0;

  if (CheckGrants) begin : g_grant_checks
    // The shared write port goes to one channel at most
    a_one_grant: assert property (@(posedge clk) disable iff (reset)
      !(grant0 && grant1))
      else begin
        fail_count++;
        $error("both write grants high in one cycle");
      end
  end

  if (CheckPush) begin : g_push_checks
    // A push that was held off is offered again unchanged
    a_push_hold: assert property (@(posedge clk) disable iff (reset)
      push_valid && !push_ready |=> push_valid && $stable(push_data))
      else begin
        fail_count++;
        $error("push valid or data changed while the push was held off");
      end
  end

endmodule

// Grant checks on the arbiter
bind shfifo_wr_arbiter shfifo_properties #(
  .CheckGrants(1'b1),
  .CheckPush  (1'b0)
) u_arb_props (
  .clk       (clk),
  .reset     (reset),
  .grant0    (grant0),
  .grant1    (grant1),
  .push_valid(),
  .push_ready(),
  .push_data ()
);

// Handshake checks on each channel
bind shfifo_channel shfifo_properties #(
  .CheckGrants(1'b0),
  .CheckPush  (1'b1)
) u_ch_props (
  .clk       (clk),
  .reset     (reset),
  .grant0    (),
  .grant1    (),
  .push_valid(push_valid),
  .push_ready(push_ready),
  .push_data (push_data)
);

//--- tb_shfifo.sv
module tb_shfifo;

  import shfifo_pkg::*;

  localparam int ClkPeriod   = 8;
  localparam int ResetCycles = 3;
  // Fields per pattern row and the row limit
  localparam int Cols        = 7;
  localparam int MaxRows     = 64;
  // Window sizes for Ch0Entries = 4
  localparam int Cap0        = 4;
  localparam int Cap1        = 28;

  logic        clk;
  logic        reset;
  logic        push_valid0;
  data_t       push_data0;
  logic        push_ready0;
  logic        pop_valid0;
  data_t       pop_data0;
  logic        pop_ready0;
  logic        push_valid1;
  data_t       push_data1;
  logic        push_ready1;
  logic        pop_valid1;
  data_t       pop_data1;
  logic        pop_ready1;

  logic [15:0] pattern [MaxRows*Cols];
  int          num_rows;
  bit          loaded;
  int          total_errors;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  int          checks;

  // Reference queues and round-robin pointer
  data_t       model_q0 [$];
  data_t       model_q1 [$];
  logic        model_prio;

  shfifo_top #(
    .Ch0Entries  (4),
    .EnableBypass(1)
  ) DUT (
    .clk        (clk),
    .reset      (reset),
    .push_valid0(push_valid0),
    .push_data0 (push_data0),
    .push_ready0(push_ready0),
    .pop_valid0 (pop_valid0),
    .pop_data0  (pop_data0),
    .pop_ready0 (pop_ready0),
    .push_valid1(push_valid1),
    .push_data1 (push_data1),
    .push_ready1(push_ready1),
    .pop_valid1 (pop_valid1),
    .pop_data1  (pop_data1),
    .pop_ready1 (pop_ready1)
  );

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  // Lone requester wins, a conflict goes to the channel whose turn it is
  function automatic logic grant_for(input logic mine, input logic other, input logic my_turn);
    return mine && (!other || my_turn);
  endfunction

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] expected);
    checks++;
    assert (got === expected) else begin
      $display("CHECK FAILED %s got %h expected %h", name, got, expected);
      test_errors++;
    end
  endtask

  task automatic report_test(input int num);
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    total_errors += test_errors;
    $display("test %0d %s, %0d errors", num, (test_errors == 0) ? "ok" : "failed", test_errors);
    test_errors = 0;
  endtask

  // One cycle: drive on the falling edge, check and step the model on the rising edge
  task automatic run_row(input int row);
    int    base;
    logic  pv0;
    logic  pv1;
    logic  pr0;
    logic  pr1;
    data_t d0;
    data_t d1;
    data_t exp_d0;
    data_t exp_d1;
    logic  empty0;
    logic  empty1;
    logic  byp0;
    logic  byp1;
    logic  full0;
    logic  full1;
    logic  req0;
    logic  req1;
    logic  gnt0;
    logic  gnt1;
    base = row * Cols;
    pv0  = pattern[base+1][0];
    d0   = pattern[base+2];
    pv1  = pattern[base+3][0];
    d1   = pattern[base+4];
    pr0  = pattern[base+5][0];
    pr1  = pattern[base+6][0];
    @(negedge clk);
    push_valid0 = pv0;
    push_data0  = d0;
    push_valid1 = pv1;
    push_data1  = d1;
    pop_ready0  = pr0;
    pop_ready1  = pr1;
    // Empty channel with a ready consumer passes the push straight through
    empty0 = (model_q0.size() == 0);
    empty1 = (model_q1.size() == 0);
    byp0   = empty0 && pr0;
    byp1   = empty1 && pr1;
    full0  = (model_q0.size() == Cap0);
    full1  = (model_q1.size() == Cap1);
    // Anything else needs the shared write port
    req0   = pv0 && !full0 && !byp0;
    req1   = pv1 && !full1 && !byp1;
    gnt0   = grant_for(req0, req1, model_prio == 1'b0);
    gnt1   = grant_for(req1, req0, model_prio == 1'b1);
    if (empty0) exp_d0 = d0;
    else        exp_d0 = model_q0[0];
    if (empty1) exp_d1 = d1;
    else        exp_d1 = model_q1[0];
    @(posedge clk);
    check_value("push_ready0", 16'(push_ready0), 16'(!full0 && (byp0 || gnt0)));
    check_value("push_ready1", 16'(push_ready1), 16'(!full1 && (byp1 || gnt1)));
    check_value("pop_valid0", 16'(pop_valid0), 16'(empty0 ? pv0 : 1'b1));
    check_value("pop_valid1", 16'(pop_valid1), 16'(empty1 ? pv1 : 1'b1));
    if (!empty0 || pv0) check_value("pop_data0", pop_data0, exp_d0);
    if (!empty1 || pv1) check_value("pop_data1", pop_data1, exp_d1);
    // Stored head leaves first, granted word joins the tail
    if (!empty0 && pr0) void'(model_q0.pop_front());
    if (!empty1 && pr1) void'(model_q1.pop_front());
    if (gnt0) model_q0.push_back(d0);
    if (gnt1) model_q1.push_back(d1);
    if (gnt0) begin
      model_prio = 1'b1;
    end else if (gnt1) begin
      model_prio = 1'b0;
    end
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    int row;
    int cur_test;
    int prop_fails;
    reset        = 1'b1;
    push_valid0  = 1'b0;
    push_data0   = '0;
    pop_ready0   = 1'b0;
    push_valid1  = 1'b0;
    push_data1   = '0;
    pop_ready1   = 1'b0;
    model_prio   = 1'b0;
    total_errors = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    checks       = 0;
    $readmemh("shfifo_patterns.txt", pattern);
    // Rows run up to the end marker with test number 0
    num_rows = 0;
    while (num_rows < MaxRows && pattern[num_rows*Cols] != 16'h0) begin
      num_rows++;
    end
    loaded = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    if (num_rows == 0) begin
      $display("no stimulus rows could be read from the pattern file");
      total_errors++;
    end else begin
      cur_test = pattern[0];
      for (row = 0; row < num_rows; row++) begin
        if (pattern[row*Cols] != cur_test) begin
          report_test(cur_test);
          cur_test = pattern[row*Cols];
        end
        run_row(row);
      end
      report_test(cur_test);
    end
    prop_fails = DUT.u_wr_arbiter.u_arb_props.fail_count
               + DUT.u_ch0.u_ch_props.fail_count
               + DUT.u_ch1.u_ch_props.fail_count;
    if (prop_fails != 0) begin
      $display("bound handshake properties failed %0d times", prop_fails);
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d, property failures %0d",
             tests_run, tests_failed, checks, total_errors, prop_fails);
    if (total_errors == 0 && prop_fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog sized from the row count, reset and a small margin
  initial begin
    wait (loaded);
    #((num_rows + ResetCycles + 12) * ClkPeriod);
    $display("watchdog expired before the pattern rows were all applied");
    $display("TB FAILED");
    $finish;
  end

endmodule

//--- project.f
shfifo_pkg.sv
shfifo_push_ctrl.sv
shfifo_pop_ctrl.sv
shfifo_channel.sv
shfifo_wr_arbiter.sv
shfifo_ram.sv
shfifo_top.sv
shfifo_properties.sv
tb_shfifo.sv

//--- shfifo_patterns.txt
// Columns: test push_valid0 push_data0 push_valid1 push_data1 pop_ready0 pop_ready1
// All fields hex, one row per clock cycle, a row with test 0 ends the list
1 0 0000 0 0000 1 1
1 0 0000 0 0000 1 1
2 1 a001 1 b001 1 1
2 1 a002 0 0000 1 1
2 0 0000 1 b002 1 1
3 1 c001 1 d001 0 0
3 1 c002 1 d001 0 0
3 1 c002 1 d002 0 0
3 0 0000 1 d002 0 0
3 0 0000 0 0000 1 1
3 0 0000 0 0000 1 1
3 0 0000 0 0000 1 1
4 1 e001 1 f001 0 0
4 1 e002 1 f001 0 0
4 1 e002 1 f002 0 0
4 1 e003 1 f002 0 0
4 1 e003 1 f003 0 0
4 1 e004 1 f003 0 0
4 1 e004 1 f004 0 0
4 1 e005 1 f004 0 0
4 1 e005 1 f005 0 0
4 1 e005 1 f006 0 0
4 1 e005 0 0000 1 1
4 1 e005 0 0000 1 1
4 0 0000 0 0000 1 1
4 0 0000 0 0000 1 1
4 0 0000 0 0000 1 1
4 0 0000 0 0000 1 1
4 0 0000 0 0000 1 1
5 1 3001 0 0000 0 1
5 1 3002 0 0000 1 1
5 1 3003 0 0000 0 1
5 1 3004 0 0000 1 1
5 1 3005 0 0000 0 1
5 1 3006 0 0000 1 1
5 1 3007 0 0000 0 1
5 1 3008 0 0000 1 1
5 1 3008 0 0000 1 1
5 0 0000 0 0000 1 1
5 0 0000 0 0000 1 1
5 0 0000 0 0000 1 1
5 0 0000 0 0000 1 1
0 0 0000 0 0000 0 0
